// File: source/loader_pkg.sv
// ROM loader definitions
`default_nettype none

package loader_pkg;

	// ########################################################################
	// Widths and download indices
	// ########################################################################
	localparam int ADDR_W       = 25; // Host byte address
	localparam int BYTE_W       = 8;
	localparam int GFX_ADDR_W   = 23; // 32-bit word address
	localparam int PROG_ADDR_W  = 15; // 16-bit word address within a bank
	localparam int LOCAL_ADDR_W = 15;
	localparam int COUNT_W      = 25; // Wide enough for any full address space
	localparam int DIP_BYTES    = 8;

	localparam logic [BYTE_W-1:0] ROM_INDEX    = 8'd0;
	localparam logic [BYTE_W-1:0] GAME_INDEX   = 8'd1;
	localparam logic [BYTE_W-1:0] DIP_INDEX    = 8'd254;
	localparam logic [BYTE_W-1:0] GAME_DEFAULT = 8'd104; // Gauntlet

	// ########################################################################
	// Memory map
	// ########################################################################
	typedef enum logic [3:0] {
		REGION_NONE, // Filler or beyond the last ROM
		REGION_GFX,  // Graphics in interleaved dwords
		REGION_9AB,  // Program banks in interleaved words
		REGION_10AB,
		REGION_7AB,
		REGION_6AB,
		REGION_5AB,
		REGION_3AB,
		REGION_16S,  // Audio as plain bytes
		REGION_16R,
		REGION_6P    // Character ROM
	} rom_region_t;

	// Graphics occupies everything below the first program bank
	localparam logic [ADDR_W-1:0] BASE_9AB  = 25'h0C0000;
	localparam logic [ADDR_W-1:0] BASE_10AB = 25'h0F0000;
	localparam logic [ADDR_W-1:0] BASE_7AB  = 25'h100000;
	localparam logic [ADDR_W-1:0] BASE_6AB  = 25'h110000;
	localparam logic [ADDR_W-1:0] BASE_5AB  = 25'h120000;
	localparam logic [ADDR_W-1:0] BASE_3AB  = 25'h130000;
	localparam logic [ADDR_W-1:0] BASE_16S  = 25'h140000;
	localparam logic [ADDR_W-1:0] BASE_16R  = 25'h148000;
	localparam logic [ADDR_W-1:0] BASE_6P   = 25'h14C000;

	localparam logic [ADDR_W-1:0] SIZE_64K = 25'h010000;
	localparam logic [ADDR_W-1:0] SIZE_32K = 25'h008000;
	localparam logic [ADDR_W-1:0] SIZE_16K = 25'h004000;

	typedef enum logic {
		ST_IDLE,
		ST_LOADING
	} load_state_t;

	function automatic logic is_prog_bank(input rom_region_t region);
		return region inside {REGION_9AB, REGION_10AB, REGION_7AB,
			REGION_6AB, REGION_5AB, REGION_3AB};
	endfunction

	// Regions written one byte at a time
	function automatic logic is_byte_region(input rom_region_t region);
		return region inside {REGION_16S, REGION_16R, REGION_6P};
	endfunction

endpackage

`default_nettype wire

// File: source/load_fsm.sv
// Download session FSM
`default_nettype none

module load_fsm (
	input  wire logic clk_sys,
	input  wire logic arst_n,
	input  wire logic dl_active, // Host session level
	output logic      load_start, // First active cycle
	output logic      load_done   // One cycle after the session ends
);

	loader_pkg::load_state_t state;

	// Start is seen in the same cycle as the first byte
	assign load_start = (state == loader_pkg::ST_IDLE) && dl_active;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state     <= loader_pkg::ST_IDLE;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0; // Pulse only
			case (state)
				loader_pkg::ST_IDLE: begin
					if (dl_active) begin
						state <= loader_pkg::ST_LOADING;
					end
				end
				loader_pkg::ST_LOADING: begin
					// Session closed by host
					if (!dl_active) begin
						state     <= loader_pkg::ST_IDLE;
						load_done <= 1'b1;
					end
				end
				default: begin
					state <= loader_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/byte_counter.sv
// Session ROM byte counter
`default_nettype none

module byte_counter (
	input  wire logic                       clk_sys,
	input  wire logic                       arst_n,
	input  wire logic                       load_start,
	input  wire logic                       rom_byte, // Accepted ROM byte
	output logic [loader_pkg::COUNT_W-1:0] byte_count
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			byte_count <= '0;
		end else if (load_start) begin
			// A byte in the start cycle already counts
			byte_count <= {{(loader_pkg::COUNT_W-1){1'b0}}, rom_byte};
		end else if (rom_byte && !(&byte_count)) begin
			byte_count <= byte_count + 1'b1; // Saturates at all ones
		end
	end

endmodule

`default_nettype wire

// File: source/region_decoder.sv
// ROM region decoder
`default_nettype none

module region_decoder (
	input  wire logic                            dl_active,
	input  wire logic                            dl_wr,
	input  wire logic [loader_pkg::BYTE_W-1:0]  dl_index,
	input  wire logic [loader_pkg::ADDR_W-1:0]  dl_addr,
	output logic                                 rom_byte,
	output loader_pkg::rom_region_t              region,
	output logic [loader_pkg::LOCAL_ADDR_W-1:0] local_addr
);

	logic [loader_pkg::ADDR_W-1:0] base;
	logic [loader_pkg::ADDR_W-1:0] size;
	logic [loader_pkg::ADDR_W-1:0] offset;

	function automatic logic in_window(
		input logic [loader_pkg::ADDR_W-1:0] addr,
		input logic [loader_pkg::ADDR_W-1:0] win_base,
		input logic [loader_pkg::ADDR_W-1:0] win_size
	);
		return (addr >= win_base) && (addr < win_base + win_size);
	endfunction

	assign rom_byte = dl_wr && dl_active && (dl_index == loader_pkg::ROM_INDEX);

	// First matching window wins
	always_comb begin
		region = loader_pkg::REGION_NONE;
		base   = '0;
		size   = '0;
		if (dl_addr < loader_pkg::BASE_9AB) begin
			region = loader_pkg::REGION_GFX;
		end else if (in_window(dl_addr, loader_pkg::BASE_9AB, loader_pkg::SIZE_64K)) begin
			region = loader_pkg::REGION_9AB;
			base   = loader_pkg::BASE_9AB;
			size   = loader_pkg::SIZE_64K;
		end else if (in_window(dl_addr, loader_pkg::BASE_10AB, loader_pkg::SIZE_32K)) begin
			region = loader_pkg::REGION_10AB; // Upper half is filler
			base   = loader_pkg::BASE_10AB;
			size   = loader_pkg::SIZE_32K;
		end else if (in_window(dl_addr, loader_pkg::BASE_7AB, loader_pkg::SIZE_64K)) begin
			region = loader_pkg::REGION_7AB;
			base   = loader_pkg::BASE_7AB;
			size   = loader_pkg::SIZE_64K;
		end else if (in_window(dl_addr, loader_pkg::BASE_6AB, loader_pkg::SIZE_64K)) begin
			region = loader_pkg::REGION_6AB;
			base   = loader_pkg::BASE_6AB;
			size   = loader_pkg::SIZE_64K;
		end else if (in_window(dl_addr, loader_pkg::BASE_5AB, loader_pkg::SIZE_64K)) begin
			region = loader_pkg::REGION_5AB;
			base   = loader_pkg::BASE_5AB;
			size   = loader_pkg::SIZE_64K;
		end else if (in_window(dl_addr, loader_pkg::BASE_3AB, loader_pkg::SIZE_64K)) begin
			region = loader_pkg::REGION_3AB;
			base   = loader_pkg::BASE_3AB;
			size   = loader_pkg::SIZE_64K;
		end else if (in_window(dl_addr, loader_pkg::BASE_16S, loader_pkg::SIZE_32K)) begin
			region = loader_pkg::REGION_16S;
			base   = loader_pkg::BASE_16S;
			size   = loader_pkg::SIZE_32K;
		end else if (in_window(dl_addr, loader_pkg::BASE_16R, loader_pkg::SIZE_16K)) begin
			region = loader_pkg::REGION_16R;
			base   = loader_pkg::BASE_16R;
			size   = loader_pkg::SIZE_16K;
		end else if (in_window(dl_addr, loader_pkg::BASE_6P, loader_pkg::SIZE_16K)) begin
			region = loader_pkg::REGION_6P;
			base   = loader_pkg::BASE_6P;
			size   = loader_pkg::SIZE_16K;
		end
	end

	// Offset masked to the window size
	assign offset = (dl_addr - base) & (size - 1'b1);

	always_comb begin
		if (loader_pkg::is_prog_bank(region)) begin
			local_addr = offset[loader_pkg::LOCAL_ADDR_W:1]; // Word offset
		end else if (loader_pkg::is_byte_region(region)) begin
			local_addr = offset[loader_pkg::LOCAL_ADDR_W-1:0];
		end else begin
			local_addr = '0; // Graphics uses the full address
		end
	end

endmodule

`default_nettype wire

// File: source/byte_packer.sv
// Byte to word packer
`default_nettype none

module byte_packer (
	input  wire logic                            clk_sys,
	input  wire logic                            arst_n,
	input  wire logic                            load_start,
	input  wire logic                            rom_byte,
	input  wire loader_pkg::rom_region_t         region,
	input  wire logic [loader_pkg::LOCAL_ADDR_W-1:0] local_addr,
	input  wire logic [loader_pkg::ADDR_W-1:0]  dl_addr,
	input  wire logic [loader_pkg::BYTE_W-1:0]  dl_data,
	output logic                                 gfx_we,
	output logic [loader_pkg::GFX_ADDR_W-1:0]   gfx_addr,
	output logic [4*loader_pkg::BYTE_W-1:0]     gfx_data,
	output logic                                 prog_we,
	output loader_pkg::rom_region_t              prog_bank,
	output logic [loader_pkg::PROG_ADDR_W-1:0]  prog_addr,
	output logic [2*loader_pkg::BYTE_W-1:0]     prog_data,
	output logic                                 byte_we,
	output loader_pkg::rom_region_t              byte_region,
	output logic [loader_pkg::LOCAL_ADDR_W-1:0] byte_addr,
	output logic [loader_pkg::BYTE_W-1:0]       byte_data
);

	logic [3*loader_pkg::BYTE_W-1:0] acc;  // Last three ROM bytes with the oldest on top
	logic [3*loader_pkg::BYTE_W-1:0] hist; // History seen by this byte
	logic gfx_hit;
	logic prog_hit;
	logic byte_hit;

	assign hist = load_start ? '0 : acc;

	// Last byte of each dword or word completes the write
	assign gfx_hit  = rom_byte && (region == loader_pkg::REGION_GFX) && (&dl_addr[1:0]);
	assign prog_hit = rom_byte && loader_pkg::is_prog_bank(region) && dl_addr[0];
	assign byte_hit = rom_byte && loader_pkg::is_byte_region(region);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			gfx_we  <= 1'b0;
			prog_we <= 1'b0;
			byte_we <= 1'b0;
		end else begin
			gfx_we  <= gfx_hit;
			prog_we <= prog_hit;
			byte_we <= byte_hit;
		end
	end

	always_ff @(posedge clk_sys) begin
		// Filler bytes shift in too
		if (rom_byte || load_start) begin
			acc <= rom_byte ? {hist[2*loader_pkg::BYTE_W-1:0], dl_data} : '0;
		end
		if (gfx_hit) begin
			gfx_addr <= dl_addr[loader_pkg::ADDR_W-1:2];
			gfx_data <= {hist, dl_data};
		end
		if (prog_hit) begin
			prog_bank <= region;
			prog_addr <= local_addr;
			prog_data <= {hist[loader_pkg::BYTE_W-1:0], dl_data}; // Even byte high
		end
		if (byte_hit) begin
			byte_region <= region;
			byte_addr   <= local_addr;
			byte_data   <= dl_data;
		end
	end

endmodule

`default_nettype wire

// File: source/config_regs.sv
// DIP switch and game type registers
`default_nettype none

module config_regs (
	input  wire logic                                        clk_sys,
	input  wire logic                                        arst_n,
	input  wire logic                                        dl_wr,
	input  wire logic [loader_pkg::BYTE_W-1:0]              dl_index,
	input  wire logic [loader_pkg::ADDR_W-1:0]              dl_addr,
	input  wire logic [loader_pkg::BYTE_W-1:0]              dl_data,
	output logic [loader_pkg::DIP_BYTES*loader_pkg::BYTE_W-1:0] dip_sw,
	output logic [loader_pkg::BYTE_W-1:0]                   game_type
);

	localparam int LANE_W = $clog2(loader_pkg::DIP_BYTES);

	logic dip_hit;

	// Only the first eight addresses hold switch banks
	assign dip_hit = dl_wr && (dl_index == loader_pkg::DIP_INDEX)
		&& (dl_addr[loader_pkg::ADDR_W-1:LANE_W] == '0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dip_sw    <= '0;
			game_type <= loader_pkg::GAME_DEFAULT;
		end else begin
			if (dip_hit) begin
				dip_sw[dl_addr[LANE_W-1:0]*loader_pkg::BYTE_W +: loader_pkg::BYTE_W] <= dl_data;
			end
			if (dl_wr && (dl_index == loader_pkg::GAME_INDEX)) begin
				game_type <= dl_data; // Selects slapstic and PROM set
			end
		end
	end

endmodule

`default_nettype wire

// File: source/rom_loader.sv
// ROM download loader
`default_nettype none

module rom_loader (
	input  wire logic                                            clk_sys,
	input  wire logic                                            arst_n,
	input  wire logic                                            dl_active,
	input  wire logic                                            dl_wr,
	input  wire logic [loader_pkg::BYTE_W-1:0]                  dl_index,
	input  wire logic [loader_pkg::ADDR_W-1:0]                  dl_addr,
	input  wire logic [loader_pkg::BYTE_W-1:0]                  dl_data,
	output logic                                                 gfx_we,
	output logic [loader_pkg::GFX_ADDR_W-1:0]                   gfx_addr,
	output logic [4*loader_pkg::BYTE_W-1:0]                     gfx_data,
	output logic                                                 prog_we,
	output loader_pkg::rom_region_t                              prog_bank,
	output logic [loader_pkg::PROG_ADDR_W-1:0]                  prog_addr,
	output logic [2*loader_pkg::BYTE_W-1:0]                     prog_data,
	output logic                                                 byte_we,
	output loader_pkg::rom_region_t                              byte_region,
	output logic [loader_pkg::LOCAL_ADDR_W-1:0]                 byte_addr,
	output logic [loader_pkg::BYTE_W-1:0]                       byte_data,
	output logic [loader_pkg::DIP_BYTES*loader_pkg::BYTE_W-1:0] dip_sw,
	output logic [loader_pkg::BYTE_W-1:0]                       game_type,
	output logic [loader_pkg::COUNT_W-1:0]                      byte_count,
	output logic                                                 load_done
);

	logic                                 load_start;
	logic                                 rom_byte;   // Accepted ROM byte this cycle
	loader_pkg::rom_region_t              region;
	logic [loader_pkg::LOCAL_ADDR_W-1:0] local_addr;

	// ########################################################################
	// Session control
	// ########################################################################
	load_fsm load_fsm_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl_active  (dl_active),
		.load_start (load_start),
		.load_done  (load_done)
	);

	byte_counter byte_counter_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.load_start (load_start),
		.rom_byte   (rom_byte),
		.byte_count (byte_count)
	);

	// ########################################################################
	// ROM data path
	// ########################################################################
	region_decoder region_decoder_i (
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.rom_byte   (rom_byte),
		.region     (region),
		.local_addr (local_addr)
	);

	byte_packer byte_packer_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.load_start  (load_start),
		.rom_byte    (rom_byte),
		.region      (region),
		.local_addr  (local_addr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.gfx_we      (gfx_we),
		.gfx_addr    (gfx_addr),
		.gfx_data    (gfx_data),
		.prog_we     (prog_we),
		.prog_bank   (prog_bank),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.byte_we     (byte_we),
		.byte_region (byte_region),
		.byte_addr   (byte_addr),
		.byte_data   (byte_data)
	);

	// Config writes work with or without a session
	config_regs config_regs_i (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dip_sw    (dip_sw),
		.game_type (game_type)
	);

endmodule

`default_nettype wire

// File: bench/rom_loader_tb_table.svh
// Download stimulus rows
// Row fields are active, write strobe, index, address and data
add_row(1'b0, 1'b0, 8'd0,   25'h000000, 8'h00); // Idle before the session
add_row(1'b1, 1'b1, 8'd0,   25'h000000, 8'h11); // Start with the first byte
add_row(1'b1, 1'b1, 8'd0,   25'h000001, 8'h22);
add_row(1'b1, 1'b1, 8'd0,   25'h000002, 8'h33);
add_row(1'b1, 1'b1, 8'd0,   25'h000003, 8'h44); // First graphics word
add_row(1'b1, 1'b1, 8'd0,   25'h000004, 8'hAA);
add_row(1'b1, 1'b1, 8'd0,   25'h000005, 8'hBB);
add_row(1'b1, 1'b1, 8'd0,   25'h000006, 8'hCC);
add_row(1'b1, 1'b1, 8'd0,   25'h000007, 8'hDD);
add_random_burst(25'h000100, 8);
add_row(1'b1, 1'b1, 8'd0,   25'h0C0010, 8'h12); // 9AB
add_row(1'b1, 1'b1, 8'd0,   25'h0C0011, 8'h34);
add_row(1'b1, 1'b1, 8'd0,   25'h0F0002, 8'h56); // 10AB
add_row(1'b1, 1'b1, 8'd0,   25'h0F0003, 8'h78);
add_row(1'b1, 1'b1, 8'd0,   25'h100004, 8'h9A); // 7AB
add_row(1'b1, 1'b1, 8'd0,   25'h100005, 8'hBC);
add_row(1'b1, 1'b1, 8'd0,   25'h11FFFE, 8'h01); // 6AB top word
add_row(1'b1, 1'b1, 8'd0,   25'h11FFFF, 8'h02);
add_row(1'b1, 1'b1, 8'd0,   25'h120000, 8'h03); // 5AB
add_row(1'b1, 1'b1, 8'd0,   25'h120001, 8'h04);
add_row(1'b1, 1'b1, 8'd0,   25'h130006, 8'h05); // 3AB
add_row(1'b1, 1'b1, 8'd0,   25'h130007, 8'h06);
add_row(1'b1, 1'b1, 8'd0,   25'h140000, 8'hA1); // 16S
add_row(1'b1, 1'b1, 8'd0,   25'h147FFF, 8'hA2);
add_row(1'b1, 1'b1, 8'd0,   25'h148000, 8'hB1); // 16R
add_row(1'b1, 1'b1, 8'd0,   25'h14BFFF, 8'hB2);
add_row(1'b1, 1'b1, 8'd0,   25'h14C000, 8'hC1); // 6P
add_row(1'b1, 1'b1, 8'd0,   25'h14FFFF, 8'hC2);
add_row(1'b1, 1'b1, 8'd0,   25'h0D0000, 8'hEE); // Filler is counted only
add_row(1'b1, 1'b1, 8'd0,   25'h0D0001, 8'hEF);
add_row(1'b1, 1'b1, 8'd0,   25'h0F8001, 8'hE0); // 10AB upper half
add_row(1'b1, 1'b1, 8'd2,   25'h000003, 8'h55); // Foreign index
add_row(1'b1, 1'b0, 8'd0,   25'h000000, 8'h00); // Gap
add_row(1'b1, 1'b1, 8'd254, 25'h000000, 8'h5A); // DIP lanes
add_row(1'b1, 1'b1, 8'd254, 25'h000007, 8'hA5);
add_row(1'b1, 1'b1, 8'd254, 25'h000008, 8'hFF); // Beyond the bank
add_row(1'b1, 1'b1, 8'd254, 25'h000003, 8'h3C);
add_row(1'b1, 1'b1, 8'd1,   25'h000000, 8'd42); // Game type
add_row(1'b0, 1'b0, 8'd0,   25'h000000, 8'h00); // Session ends
add_row(1'b0, 1'b1, 8'd0,   25'h000003, 8'h99); // ROM byte while inactive
add_row(1'b0, 1'b1, 8'd254, 25'h000001, 8'h77); // DIP needs no session
add_row(1'b1, 1'b1, 8'd0,   25'h000011, 8'h61); // Second session opens mid word
add_row(1'b1, 1'b1, 8'd0,   25'h000012, 8'h62);
add_row(1'b1, 1'b1, 8'd0,   25'h000013, 8'h63); // Top byte from the cleared accumulator
add_row(1'b1, 1'b1, 8'd0,   25'h000014, 8'h64);
add_row(1'b1, 1'b0, 8'd0,   25'h000000, 8'h00);
add_row(1'b0, 1'b0, 8'd0,   25'h000000, 8'h00);
add_row(1'b0, 1'b0, 8'd0,   25'h000000, 8'h00);

// File: bench/rom_loader_tb.sv
// ROM loader testbench
`default_nettype none

module rom_loader_tb;

	typedef struct packed {
		logic                            act;
		logic                            wr;
		logic [loader_pkg::BYTE_W-1:0]  idx;
		logic [loader_pkg::ADDR_W-1:0]  addr;
		logic [loader_pkg::BYTE_W-1:0]  data;
	} stim_row_t;

	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 5;
	localparam int CHECK_DELAY  = 1; // Outputs settled after the edge
	localparam int DRIVE_DELAY  = 1; // Added to the check delay

	logic                                                 clk_sys;
	logic                                                 arst_n;
	logic                                                 dl_active;
	logic                                                 dl_wr;
	logic [loader_pkg::BYTE_W-1:0]                       dl_index;
	logic [loader_pkg::ADDR_W-1:0]                       dl_addr;
	logic [loader_pkg::BYTE_W-1:0]                       dl_data;
	logic                                                 gfx_we;
	logic [loader_pkg::GFX_ADDR_W-1:0]                   gfx_addr;
	logic [4*loader_pkg::BYTE_W-1:0]                     gfx_data;
	logic                                                 prog_we;
	loader_pkg::rom_region_t                              prog_bank;
	logic [loader_pkg::PROG_ADDR_W-1:0]                  prog_addr;
	logic [2*loader_pkg::BYTE_W-1:0]                     prog_data;
	logic                                                 byte_we;
	loader_pkg::rom_region_t                              byte_region;
	logic [loader_pkg::LOCAL_ADDR_W-1:0]                 byte_addr;
	logic [loader_pkg::BYTE_W-1:0]                       byte_data;
	logic [loader_pkg::DIP_BYTES*loader_pkg::BYTE_W-1:0] dip_sw;
	logic [loader_pkg::BYTE_W-1:0]                       game_type;
	logic [loader_pkg::COUNT_W-1:0]                      byte_count;
	logic                                                 load_done;

	stim_row_t stim_q[$];
	int        errors;
	int        checks;
	int        cycles = 0;
	int        cycle_limit;

	// Reference model state
	logic                                                 m_active;
	logic [3*loader_pkg::BYTE_W-1:0]                     m_acc;   // Oldest byte on top
	logic [loader_pkg::COUNT_W-1:0]                      m_count;
	logic [loader_pkg::DIP_BYTES*loader_pkg::BYTE_W-1:0] m_dip;
	logic [loader_pkg::BYTE_W-1:0]                       m_game;

	// Expected outputs after the next edge
	logic                                exp_gfx_we;
	logic [loader_pkg::GFX_ADDR_W-1:0]   exp_gfx_addr;
	logic [4*loader_pkg::BYTE_W-1:0]     exp_gfx_data;
	logic                                exp_prog_we;
	loader_pkg::rom_region_t             exp_prog_bank;
	logic [loader_pkg::PROG_ADDR_W-1:0]  exp_prog_addr;
	logic [2*loader_pkg::BYTE_W-1:0]     exp_prog_data;
	logic                                exp_byte_we;
	loader_pkg::rom_region_t             exp_byte_region;
	logic [loader_pkg::LOCAL_ADDR_W-1:0] exp_byte_addr;
	logic [loader_pkg::BYTE_W-1:0]       exp_byte_data;
	logic                                exp_done;

	rom_loader rom_loader_i (.*);

	always #CLK_HALF clk_sys = ~clk_sys; // 40 unit period

	// Run length guard
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("TIMEOUT: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ########################################################################
	// Stimulus table
	// ########################################################################
	task automatic add_row(input logic act, input logic wr, input logic [7:0] idx,
		input logic [loader_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
		stim_q.push_back({act, wr, idx, addr, data});
	endtask

	// Consecutive ROM bytes with random data
	task automatic add_random_burst(input logic [loader_pkg::ADDR_W-1:0] addr, input int n);
		logic [31:0] r;
		for (int k = 0; k < n; k++) begin
			r = $urandom();
			add_row(1'b1, 1'b1, loader_pkg::ROM_INDEX, addr + k, r[7:0]);
		end
	endtask

	task automatic build_table();
		`include "rom_loader_tb_table.svh"
	endtask

	task automatic drive_row(input stim_row_t row);
		dl_active = row.act;
		dl_wr     = row.wr;
		dl_index  = row.idx;
		dl_addr   = row.addr;
		dl_data   = row.data;
	endtask

	// ########################################################################
	// Reference model
	// ########################################################################
	// Memory map with filler holes decoding to none
	task automatic decode_ref(input logic [loader_pkg::ADDR_W-1:0] a,
		output loader_pkg::rom_region_t rgn, output logic [loader_pkg::ADDR_W-1:0] base);
		rgn  = loader_pkg::REGION_NONE;
		base = '0;
		if (a < 25'h0C0000) begin
			rgn = loader_pkg::REGION_GFX;
		end else if (a < 25'h0D0000) begin
			rgn  = loader_pkg::REGION_9AB;
			base = 25'h0C0000;
		end else if (a >= 25'h0F0000 && a < 25'h0F8000) begin
			rgn  = loader_pkg::REGION_10AB; // Only 32 KB populated
			base = 25'h0F0000;
		end else if (a >= 25'h100000 && a < 25'h110000) begin
			rgn  = loader_pkg::REGION_7AB;
			base = 25'h100000;
		end else if (a >= 25'h110000 && a < 25'h120000) begin
			rgn  = loader_pkg::REGION_6AB;
			base = 25'h110000;
		end else if (a >= 25'h120000 && a < 25'h130000) begin
			rgn  = loader_pkg::REGION_5AB;
			base = 25'h120000;
		end else if (a >= 25'h130000 && a < 25'h140000) begin
			rgn  = loader_pkg::REGION_3AB;
			base = 25'h130000;
		end else if (a >= 25'h140000 && a < 25'h148000) begin
			rgn  = loader_pkg::REGION_16S;
			base = 25'h140000;
		end else if (a >= 25'h148000 && a < 25'h14C000) begin
			rgn  = loader_pkg::REGION_16R;
			base = 25'h148000;
		end else if (a >= 25'h14C000 && a < 25'h150000) begin
			rgn  = loader_pkg::REGION_6P;
			base = 25'h14C000;
		end
	endtask

	task automatic model_step(input stim_row_t row);
		logic                            start;
		logic                            rom;
		loader_pkg::rom_region_t         rgn;
		logic [loader_pkg::ADDR_W-1:0]   base;
		logic [loader_pkg::ADDR_W-1:0]   off;
		logic [3*loader_pkg::BYTE_W-1:0] hist;
		start    = row.act && !m_active; // Rising session level
		exp_done = m_active && !row.act;
		m_active = row.act;
		rom      = row.wr && row.act && (row.idx == loader_pkg::ROM_INDEX);
		decode_ref(row.addr, rgn, base);
		off  = row.addr - base;
		hist = start ? '0 : m_acc;
		exp_gfx_we      = rom && (rgn == loader_pkg::REGION_GFX) && (row.addr[1:0] == 2'b11);
		exp_gfx_addr    = row.addr[loader_pkg::ADDR_W-1:2];
		exp_gfx_data    = {hist, row.data};
		exp_prog_we     = rom && row.addr[0] && (rgn inside {loader_pkg::REGION_9AB,
			loader_pkg::REGION_10AB, loader_pkg::REGION_7AB, loader_pkg::REGION_6AB,
			loader_pkg::REGION_5AB, loader_pkg::REGION_3AB});
		exp_prog_bank   = rgn;
		exp_prog_addr   = off[15:1]; // Word within the 64 KB window
		exp_prog_data   = {hist[7:0], row.data};
		exp_byte_we     = rom && (rgn inside {loader_pkg::REGION_16S, loader_pkg::REGION_16R,
			loader_pkg::REGION_6P});
		exp_byte_region = rgn;
		exp_byte_addr   = (rgn == loader_pkg::REGION_16S) ? off[14:0] : {1'b0, off[13:0]};
		exp_byte_data   = row.data;
		if (rom) begin
			m_acc = {hist[15:0], row.data};
		end else if (start) begin
			m_acc = '0;
		end
		if (start) m_count = '0;
		if (rom) m_count = m_count + 1;
		if (row.wr && row.idx == loader_pkg::DIP_INDEX && row.addr < 8) begin
			m_dip[row.addr[2:0]*8 +: 8] = row.data;
		end
		if (row.wr && row.idx == loader_pkg::GAME_INDEX) m_game = row.data;
	endtask

	// ########################################################################
	// Compare tasks
	// ########################################################################
	task automatic report_mismatch(input string what);
		errors++;
		$display("MISMATCH at time %0t: %s", $time, what);
	endtask

	task automatic check_gfx(input logic we, input logic [loader_pkg::GFX_ADDR_W-1:0] addr,
		input logic [4*loader_pkg::BYTE_W-1:0] data);
		checks++;
		if (gfx_we !== we) begin
			report_mismatch($sformatf("gfx_we is %0b, expected %0b", gfx_we, we));
		end else if (we && (gfx_addr !== addr || gfx_data !== data)) begin
			report_mismatch($sformatf("gfx write %h:%h, expected %h:%h",
				gfx_addr, gfx_data, addr, data));
		end
	endtask

	task automatic check_prog(input logic we, input loader_pkg::rom_region_t bank,
		input logic [loader_pkg::PROG_ADDR_W-1:0] addr, input logic [15:0] data);
		checks++;
		if (prog_we !== we) begin
			report_mismatch($sformatf("prog_we is %0b, expected %0b", prog_we, we));
		end else if (we && (prog_bank !== bank || prog_addr !== addr || prog_data !== data)) begin
			report_mismatch($sformatf("prog write %s %h:%h, expected %s %h:%h",
				prog_bank.name(), prog_addr, prog_data, bank.name(), addr, data));
		end
	endtask

	task automatic check_byte(input logic we, input loader_pkg::rom_region_t rgn,
		input logic [loader_pkg::LOCAL_ADDR_W-1:0] addr, input logic [7:0] data);
		checks++;
		if (byte_we !== we) begin
			report_mismatch($sformatf("byte_we is %0b, expected %0b", byte_we, we));
		end else if (we && (byte_region !== rgn || byte_addr !== addr || byte_data !== data)) begin
			report_mismatch($sformatf("byte write %s %h:%h, expected %s %h:%h",
				byte_region.name(), byte_addr, byte_data, rgn.name(), addr, data));
		end
	endtask

	task automatic check_config(input logic [loader_pkg::DIP_BYTES*8-1:0] dip,
		input logic [7:0] game);
		checks++;
		if (dip_sw !== dip || game_type !== game) begin
			report_mismatch($sformatf("dip_sw %h game_type %0d, expected %h %0d",
				dip_sw, game_type, dip, game));
		end
	endtask

	task automatic check_session(input logic [loader_pkg::COUNT_W-1:0] count, input logic done);
		checks++;
		if (byte_count !== count || load_done !== done) begin
			report_mismatch($sformatf("byte_count %0d load_done %0b, expected %0d %0b",
				byte_count, load_done, count, done));
		end
	endtask

	task automatic check_all();
		check_gfx(exp_gfx_we, exp_gfx_addr, exp_gfx_data);
		check_prog(exp_prog_we, exp_prog_bank, exp_prog_addr, exp_prog_data);
		check_byte(exp_byte_we, exp_byte_region, exp_byte_addr, exp_byte_data);
		check_config(m_dip, m_game);
		check_session(m_count, exp_done);
	endtask

	// ########################################################################
	// Main sequence
	// ########################################################################
	initial begin
		clk_sys   = 1'b0;
		arst_n    = 1'b0;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_data   = '0;
		errors    = 0;
		checks    = 0;
		m_active  = 1'b0;
		m_acc     = '0;
		m_count   = '0;
		m_dip     = '0;
		m_game    = loader_pkg::GAME_DEFAULT; // Reset values
		{exp_gfx_we, exp_prog_we, exp_byte_we, exp_done} = '0;
		void'($urandom(32'h13d0));
		build_table();
		cycle_limit = stim_q.size() + RESET_CYCLES + 20;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#(CHECK_DELAY + DRIVE_DELAY) arst_n = 1'b1;
		foreach (stim_q[i]) begin
			@(posedge clk_sys);
			#CHECK_DELAY check_all(); // Result of the previous row
			#DRIVE_DELAY drive_row(stim_q[i]);
			model_step(stim_q[i]);
		end
		@(posedge clk_sys);
		#CHECK_DELAY check_all();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rom_loader.f
+incdir+bench
source/loader_pkg.sv
source/load_fsm.sv
source/byte_counter.sv
source/region_decoder.sv
source/byte_packer.sv
source/config_regs.sv
source/rom_loader.sv
bench/rom_loader_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
TOP       := rom_loader_tb
RTL_TOP   := rom_loader
FILELIST  := rom_loader.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
